/* design/histBuilder.sv */
module histBuilder #(
    parameter int COUNT_W = sifhPkg::COUNT_W
) (
    input  logic           clk,
    input  logic           res,
    input  logic           laneHit,
    input  sifhPkg::binT   laneBin,
    input  logic           scanEn,
    input  sifhPkg::binT   scanAddr,
    output sifhPkg::countT scanCount
);

    // counts stop here
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1;

    // bin memory of this pixel
    logic [COUNT_W-1:0] countMem [sifhPkg::BIN_NUM];

    // write stage, one hit behind the read stage
    logic               wrValid;
    sifhPkg::binT       wrBin;
    logic [COUNT_W-1:0] rdCount;
    logic [COUNT_W-1:0] wrCount;

    // incoming bin matches the bin being written right now
    logic               fwdHit;

    assign fwdHit = wrValid && (wrBin == laneBin);

    // saturating increment of the read value
    assign wrCount = (rdCount == COUNT_MAX) ? rdCount : rdCount + 1'b1;

    // write stage valid
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrValid <= 1'b0;
        end else begin
            wrValid <= laneHit;
        end
    end

    // read stage
    // memory word is stale when the same bin is being written this edge,
    // so the pending value is taken instead
    always_ff @(posedge clk) begin
        if (laneHit) begin
            wrBin <= laneBin;
            if (fwdHit) begin
                rdCount <= wrCount;
            end else begin
                rdCount <= countMem[laneBin];
            end
        end
    end

    // memory write port
    // hit writes and scan clears never overlap, busy keeps them apart
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < sifhPkg::BIN_NUM; i++) begin
                countMem[i] <= '0;
            end
        end else begin
            if (wrValid) begin
                countMem[wrBin] <= wrCount;
            end
            // clear behind the scan
            if (scanEn) begin
                countMem[scanAddr] <= '0;
            end
        end
    end

    // scan read, one cycle after the address
    // zero extended to the shared count width
    always_ff @(posedge clk) begin
        if (scanEn) begin
            scanCount <= sifhPkg::countT'(countMem[scanAddr]);
        end
    end

endmodule

/* design/hitDispatcher.sv */
module hitDispatcher #(
    parameter int PIXEL_NUM = sifhPkg::PIXEL_NUM
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 hitValid,
    input  sifhPkg::pixelT       hitPixel,
    input  sifhPkg::binT         hitBin,
    input  logic                 busy,
    output logic [PIXEL_NUM-1:0] laneHit,
    output sifhPkg::binT         laneBin
);

    // hit survives only while the readout is idle
    logic                 hitTaken;
    // one-hot lane select before the register
    logic [PIXEL_NUM-1:0] laneSel;

    // busy already covers the frame end cycle itself
    assign hitTaken = hitValid && !busy;

    // pixel number to one strobe per lane
    always_comb begin
        for (int i = 0; i < PIXEL_NUM; i++) begin
            laneSel[i] = hitTaken && (hitPixel == sifhPkg::pixelT'(i));
        end
    end

    // lane strobes, single cycle per accepted hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            laneHit <= '0;
        end else begin
            laneHit <= laneSel;
        end
    end

    // bin is shared by all lanes
    // only the strobed lane looks at it
    always_ff @(posedge clk) begin
        if (hitTaken) begin
            laneBin <= hitBin;
        end
    end

endmodule

/* design/peakReadout.sv */
module peakReadout #(
    parameter int PIXEL_NUM = sifhPkg::PIXEL_NUM,
    parameter int COUNT_W   = sifhPkg::COUNT_W
) (
    input  logic                                            clk,
    input  logic                                            res,
    input  logic                                            frameEnd,
    input  logic [PIXEL_NUM*$bits(sifhPkg::countT)-1:0]     scanCount,
    output logic                                            busy,
    output logic                                            scanEn,
    output sifhPkg::binT                                    scanAddr,
    output logic                                            peakValid,
    output sifhPkg::pixelT                                  peakPixel,
    output sifhPkg::binT                                    peakBin,
    output sifhPkg::countT                                  peakCount
);

    // slice width of one lane in scanCount
    localparam int CNT_BITS = $bits(sifhPkg::countT);
    localparam sifhPkg::binT   LAST_BIN   = sifhPkg::binT'(sifhPkg::BIN_NUM - 1);
    localparam sifhPkg::pixelT LAST_PIXEL = sifhPkg::pixelT'(PIXEL_NUM - 1);

    sifhPkg::readoutStateT state;
    sifhPkg::readoutStateT stateNext;

    // second drain cycle
    logic                  drainCnt;
    sifhPkg::pixelT        pixelCnt;

    // lane results trail the address by one cycle
    logic                  resultValid;
    sifhPkg::binT          resultBin;

    // running maximum per lane
    logic [COUNT_W-1:0]    bestCount [PIXEL_NUM];
    sifhPkg::binT          bestBin   [PIXEL_NUM];
    // maximum including the result on the bus this cycle
    logic [COUNT_W-1:0]    mergeCount [PIXEL_NUM];
    sifhPkg::binT          mergeBin   [PIXEL_NUM];

    always_comb begin
        stateNext = state;
        case (state)
            sifhPkg::IDLE: begin
                if (frameEnd) begin
                    stateNext = sifhPkg::DRAIN;
                end
            end
            // two cycles, enough for the lane pipeline to settle
            sifhPkg::DRAIN: begin
                if (drainCnt) begin
                    stateNext = sifhPkg::SCAN;
                end
            end
            sifhPkg::SCAN: begin
                if (scanAddr == LAST_BIN) begin
                    stateNext = sifhPkg::REPORT;
                end
            end
            sifhPkg::REPORT: begin
                if (pixelCnt == LAST_PIXEL) begin
                    stateNext = sifhPkg::IDLE;
                end
            end
            default: stateNext = sifhPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sifhPkg::IDLE;
            drainCnt    <= 1'b0;
            scanAddr    <= '0;
            pixelCnt    <= '0;
            resultValid <= 1'b0;
        end else begin
            state       <= stateNext;
            drainCnt    <= (state == sifhPkg::DRAIN) ? !drainCnt : 1'b0;
            // wraps back to 0 after the last bin
            scanAddr    <= scanEn ? scanAddr + 1'b1 : '0;
            pixelCnt    <= peakValid ? pixelCnt + 1'b1 : '0;
            resultValid <= scanEn;
        end
    end

    // bin that the current lane results belong to
    always_ff @(posedge clk) begin
        resultBin <= scanAddr;
    end

    // strictly greater wins, so ascending scan keeps the lowest bin on ties
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            mergeCount[p] = bestCount[p];
            mergeBin[p]   = bestBin[p];
            if (resultValid && (scanCount[p*CNT_BITS +: COUNT_W] > bestCount[p])) begin
                mergeCount[p] = scanCount[p*CNT_BITS +: COUNT_W];
                mergeBin[p]   = resultBin;
            end
        end
    end

    // empty histogram ends up as bin 0, count 0
    always_ff @(posedge clk) begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (state == sifhPkg::DRAIN) begin
                bestCount[p] <= '0;
                bestBin[p]   <= '0;
            end else begin
                bestCount[p] <= mergeCount[p];
                bestBin[p]   <= mergeBin[p];
            end
        end
    end

    // frame end raises busy in its own cycle, a hit next to it is dropped
    assign busy      = (state != sifhPkg::IDLE) || frameEnd;
    assign scanEn    = (state == sifhPkg::SCAN);

    // first report already folds in the last scan result
    assign peakValid = (state == sifhPkg::REPORT);
    assign peakPixel = pixelCnt;
    assign peakBin   = mergeBin[pixelCnt];
    assign peakCount = sifhPkg::countT'(mergeCount[pixelCnt]);

endmodule

/* design/sifhPkg.sv */
package sifhPkg;

    // default array size, both powers of two
    localparam int PIXEL_NUM = 4;
    localparam int BIN_NUM   = 16;

    // widest count a bin can hold
    localparam int COUNT_W   = 8;

    localparam int PIXEL_W   = $clog2(PIXEL_NUM);
    localparam int BIN_W     = $clog2(BIN_NUM);

    // pixel number, one per lane
    typedef logic [PIXEL_W-1:0] pixelT;

    // bin number or scan address
    typedef logic [BIN_W-1:0] binT;

    // one bin count, narrower counters are zero extended into it
    typedef logic [COUNT_W-1:0] countT;

    // frame end sequence of the peak readout
    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SCAN,
        REPORT
    } readoutStateT;

endpackage

/* design/sifhTop.sv */
module sifhTop #(
    parameter int PIXEL_NUM = sifhPkg::PIXEL_NUM,
    parameter int COUNT_W   = sifhPkg::COUNT_W
) (
    input  logic           clk,
    input  logic           res,
    input  logic           hitValid,
    input  sifhPkg::pixelT hitPixel,
    input  sifhPkg::binT   hitBin,
    input  logic           frameEnd,
    output logic           busy,
    output logic           peakValid,
    output sifhPkg::pixelT peakPixel,
    output sifhPkg::binT   peakBin,
    output sifhPkg::countT peakCount
);

    localparam int CNT_BITS = $bits(sifhPkg::countT);

    // dispatcher to lanes
    logic [PIXEL_NUM-1:0]          laneHit;
    sifhPkg::binT                  laneBin;

    // readout to lanes and back
    logic                          scanEn;
    sifhPkg::binT                  scanAddr;
    logic [PIXEL_NUM*CNT_BITS-1:0] scanCount;

    hitDispatcher #(
        .PIXEL_NUM (PIXEL_NUM)
    ) uDispatcher (
        .clk      (clk),
        .res      (res),
        .hitValid (hitValid),
        .hitPixel (hitPixel),
        .hitBin   (hitBin),
        .busy     (busy),
        .laneHit  (laneHit),
        .laneBin  (laneBin)
    );

    // one lane per pixel, all scanned in lockstep
    for (genvar i = 0; i < PIXEL_NUM; i++) begin : gLane
        histBuilder #(
            .COUNT_W (COUNT_W)
        ) uLane (
            .clk       (clk),
            .res       (res),
            .laneHit   (laneHit[i]),
            .laneBin   (laneBin),
            .scanEn    (scanEn),
            .scanAddr  (scanAddr),
            .scanCount (scanCount[i*CNT_BITS +: CNT_BITS])
        );
    end

    peakReadout #(
        .PIXEL_NUM (PIXEL_NUM),
        .COUNT_W   (COUNT_W)
    ) uReadout (
        .clk       (clk),
        .res       (res),
        .frameEnd  (frameEnd),
        .scanCount (scanCount),
        .busy      (busy),
        .scanEn    (scanEn),
        .scanAddr  (scanAddr),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

/* dv/clockGen.sv */
module clockGen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic res
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held low for the first few rising edges
    initial begin
        res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b1;
    end

endmodule

/* dv/sifhCases.txt */
# H pixel bin n: n hits with random gaps, B: n hits back to back, D: n hits sent while busy
# F name: frame end, P: expected bin and count for pixel 0, 1, 2, 3
H 0 3 3
H 1 10 2
H 0 5 1
H 2 15 2
H 1 2 1
H 2 0 1
H 3 7 1
F distinct
P 3 3 10 2 15 2 7 1
B 1 6 5
H 1 4 2
B 3 12 3
H 3 12 1
F burst
P 0 0 6 5 0 0 12 4
H 0 8 2
H 0 2 2
B 1 9 3
B 1 1 3
H 2 5 1
H 2 4 1
F tie
P 2 2 1 3 4 1 0 0
B 2 11 20
H 0 13 16
D 3 14 6
F saturate
P 13 15 0 0 11 15 0 0
H 3 1 1
H 2 9 2
F clear
P 0 0 0 0 9 2 1 1

/* dv/sifhTb.sv */
module sifhTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIXELS      = 4;
    localparam int LATENCY     = 19;
    localparam int HIT_CYCLES  = 4;
    localparam int FRAME_SLACK = 30;
    localparam int END_SLACK   = 50;
    localparam logic [15:0] SEED = 16'd90;
    localparam CASE_FILE = "dv/sifhCases.txt";

    logic           clk;
    logic           res;
    logic           hitValid;
    sifhPkg::pixelT hitPixel;
    sifhPkg::binT   hitBin;
    logic           frameEnd;
    logic           busy;
    logic           peakValid;
    sifhPkg::pixelT peakPixel;
    sifhPkg::binT   peakBin;
    sifhPkg::countT peakCount;

    // record kinds in file order
    byte   kindQ [$];
    // hit fields consumed in order by H, B and D records
    int    pixQ [$];
    int    binQ [$];
    int    repQ [$];
    string nameQ [$];
    // expected bin and count with four entries per frame
    int    expBinQ [$];
    int    expCntQ [$];
    // hits waiting for the next frame end
    int    dropPixQ [$];
    int    dropBinQ [$];

    logic [15:0] lfsr       = SEED;
    int          cycleCnt   = 0;
    int          cycleLimit = 0;
    int          passCnt    = 0;
    int          failCnt    = 0;

    clockGen uClock (
        .clk (clk),
        .res (res)
    );

    // 4 bit counts so saturation shows up after 15 hits
    sifhTop #(
        .PIXEL_NUM (PIXELS),
        .COUNT_W   (4)
    ) u_dut (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid),
        .hitPixel  (hitPixel),
        .hitBin    (hitBin),
        .frameEnd  (frameEnd),
        .busy      (busy),
        .peakValid (peakValid),
        .peakPixel (peakPixel),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextRandomBit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // 0 to 3 idle cycles from two fresh bits
    function automatic int pickGap();
        int gap;
        gap = nextRandomBit();
        gap = 2 * gap + nextRandomBit();
        return gap;
    endfunction

    task automatic readCases(output bit ok);
        int    fd;
        string line;
        string name;
        byte   kind;
        int    a;
        int    b;
        int    c;
        int    e [8];
        fd = $fopen(CASE_FILE, "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank lines and comments skipped
            if (line.len() > 1 && line[0] != "#") begin
                kind = line[0];
                if (kind == "F") begin
                    void'($sscanf(line, "%c %s", kind, name));
                    nameQ.push_back(name);
                    kindQ.push_back(kind);
                end else if (kind == "P") begin
                    void'($sscanf(line, "%c %d %d %d %d %d %d %d %d", kind,
                        e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]));
                    for (int p = 0; p < PIXELS; p++) begin
                        expBinQ.push_back(e[2*p]);
                        expCntQ.push_back(e[2*p+1]);
                    end
                end else begin
                    void'($sscanf(line, "%c %d %d %d", kind, a, b, c));
                    kindQ.push_back(kind);
                    pixQ.push_back(a);
                    binQ.push_back(b);
                    repQ.push_back(c);
                end
            end
        end
    endtask

    task automatic sendHit(input int pixel, input int bin);
        @(posedge clk);
        hitValid <= 1'b1;
        hitPixel <= sifhPkg::pixelT'(pixel);
        hitBin   <= sifhPkg::binT'(bin);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hitValid <= 1'b0;
        end
    endtask

    // one queued hit per busy cycle starting on the frame end cycle
    task automatic driveDropped();
        if (dropPixQ.size() > 0) begin
            hitValid <= 1'b1;
            hitPixel <= sifhPkg::pixelT'(dropPixQ.pop_front());
            hitBin   <= sifhPkg::binT'(dropBinQ.pop_front());
        end else begin
            hitValid <= 1'b0;
        end
    endtask

    task automatic runFrame(input string name);
        int errs;
        int waitCycles;
        int expBin;
        int expCnt;
        errs       = 0;
        waitCycles = 0;
        @(posedge clk);
        frameEnd <= 1'b1;
        driveDropped();
        @(negedge clk);
        assert (busy) else begin
            $display("ERROR at %0d ns: busy low during frame end", $time);
            errs++;
        end
        // count cycles until the first report
        do begin
            @(posedge clk);
            frameEnd <= 1'b0;
            driveDropped();
            @(negedge clk);
            waitCycles++;
        end while (!peakValid);
        assert (waitCycles == LATENCY) else begin
            $display("ERROR at %0d ns: first peak after %0d cycles, expected %0d",
                $time, waitCycles, LATENCY);
            errs++;
        end
        // reports on consecutive cycles with pixel 0 first
        for (int p = 0; p < PIXELS; p++) begin
            expBin = expBinQ.pop_front();
            expCnt = expCntQ.pop_front();
            if (p > 0) begin
                @(negedge clk);
            end
            assert (peakValid && peakPixel == p) else begin
                $display("ERROR at %0d ns: report for pixel %0d missing", $time, p);
                errs++;
            end
            assert (peakBin == expBin) else begin
                $display("ERROR at %0d ns: pixel %0d bin %0d, expected %0d",
                    $time, p, peakBin, expBin);
                errs++;
            end
            assert (peakCount == expCnt) else begin
                $display("ERROR at %0d ns: pixel %0d count %0d, expected %0d",
                    $time, p, peakCount, expCnt);
                errs++;
            end
        end
        @(negedge clk);
        assert (!busy && !peakValid) else begin
            $display("ERROR at %0d ns: busy or peakValid high after last report", $time);
            errs++;
        end
        if (errs == 0) begin
            passCnt++;
            $display("test %s passed", name);
        end else begin
            failCnt++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    // run limit from the length of the case file
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
            $display("timed out waiting for peaks after %0d cycles", cycleCnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        bit ok;
        int hits;
        int pixel;
        int bin;
        int rep;
        hitValid = 1'b0;
        hitPixel = '0;
        hitBin   = '0;
        frameEnd = 1'b0;
        readCases(ok);
        if (!ok) begin
            $display("could not open case file %s", CASE_FILE);
            $display("Simulation failed");
            $finish;
        end else begin
            hits = 0;
            foreach (repQ[i]) begin
                hits += repQ[i];
            end
            cycleLimit = hits * HIT_CYCLES + nameQ.size() * FRAME_SLACK + END_SLACK;
            wait (res === 1'b1);
            foreach (kindQ[i]) begin
                if (kindQ[i] == "F") begin
                    runFrame(nameQ.pop_front());
                end else begin
                    pixel = pixQ.pop_front();
                    bin   = binQ.pop_front();
                    rep   = repQ.pop_front();
                    repeat (rep) begin
                        if (kindQ[i] == "D") begin
                            dropPixQ.push_back(pixel);
                            dropBinQ.push_back(bin);
                        end else begin
                            sendHit(pixel, bin);
                            // burst hits go out back to back
                            if (kindQ[i] == "H") begin
                                idleCycles(pickGap());
                            end
                        end
                    end
                end
            end
            $display("tests passed %0d failed %0d", passCnt, failCnt);
            if (failCnt == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* vlog.f */
design/sifhPkg.sv
design/hitDispatcher.sv
design/histBuilder.sv
design/peakReadout.sv
design/sifhTop.sv
dv/clockGen.sv
dv/sifhTb.sv
